// File: dv/tb_st_glue.sv
// random bus cycles against a behavioral model; outputs sampled on the falling clk_8 edge
`timescale 1ns/10ps
`include "st_glue_macros.svh"

module tb_st_glue;

	logic clk_8 = 1'b0;
	logic pll_locked, cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_rw, cpu_clr_berr;
	logic dma_br, video_read, vsync, hsync, mfp_irq;
	logic cpu_dtack_n, cpu_berr, ram_oe_n, ram_we_n, ram_uds_n, ram_lds_n;
	logic vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel, mfp_iack, io_sel;
	st_glue_pkg::word_addr_t cpu_addr, video_addr, ram_addr;
	st_glue_pkg::mem_cfg_e mem_cfg;
	st_glue_pkg::data_t ram_rdata, vreg_rdata, dma_rdata, cpu_rdata;
	st_glue_pkg::byte_t mmu_rdata, mfp_rdata, acia_rdata, psg_rdata;
	st_glue_pkg::bus_phase_e bus_phase;
	st_glue_pkg::ipl_t cpu_ipl;
	integer seed;
	int errors = 0;
	int checks = 0;

	always #10 clk_8 = !clk_8;  // 50 MHz stand-in for the 8 MHz bus clock

	st_glue_top UUT (.*);

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// byte address ranges of the st map
	function automatic logic ram_region(input logic [23:0] a, input st_glue_pkg::mem_cfg_e cfg);
		ram_region = (a < 24'h400000) ||
			((cfg == st_glue_pkg::MEM_8M || cfg == st_glue_pkg::MEM_14M) && a < 24'h800000) ||
			(cfg == st_glue_pkg::MEM_14M && a < 24'he00000);
	endfunction

	function automatic logic rom_region(input logic [23:0] a);
		rom_region = (a >= 24'he00000 && a < 24'he40000) ||  // tos 256k
			(a >= 24'hfa0000 && a < 24'hff0000);             // cart + tos 192k
	endfunction

	// {vreg, mmu, mfp, acia, psg, dma} for an offset inside the io page
	function automatic logic [5:0] io_decode(input logic [15:0] o);
		io_decode[5] = (o >= `ST_VREG_BASE) && (o < `ST_VREG_BASE + 16'h80);
		io_decode[4] = (o >= `ST_MMU_BASE) && (o < `ST_MMU_BASE + 16'h2);
		io_decode[3] = (o >= `ST_MFP_BASE) && (o < `ST_MFP_BASE + 16'h40);
		io_decode[2] = (o >= `ST_ACIA_BASE) && (o < `ST_ACIA_BASE + 16'h100);
		io_decode[1] = (o >= `ST_PSG_BASE) && (o < `ST_PSG_BASE + 16'h100);
		io_decode[0] = (o >= `ST_DMA_BASE) && (o < `ST_DMA_BASE + 16'h10);
	endfunction

	// weighted mix of byte addresses
	function automatic logic [23:0] pick_addr();
		logic [31:0] r;
		logic [15:0] bases [6] = '{`ST_MMU_BASE, `ST_VREG_BASE, `ST_DMA_BASE,
			`ST_PSG_BASE, `ST_MFP_BASE, `ST_ACIA_BASE};
		r = $random(seed);
		case (r[2:0])
			3'd0, 3'd1: pick_addr = r[31:8] % 24'he00000;  // ram up to 14M
			3'd2: pick_addr = r[8] ? 24'he00000 + r[31:14] : 24'hfa0000 + (r[31:13] % 19'h50000);
			3'd3, 3'd4: pick_addr = {8'hff, bases[r[10:8] % 6]} + {r[15:12], 1'b0};  // near a base
			3'd5: pick_addr = {20'hfffff, r[11:9], 1'b0};  // iack, any level
			3'd6: pick_addr = {8'hff, r[31:16]};           // io page, mostly unmapped
			default: pick_addr = r[31:8];
		endcase
	endfunction

	task automatic wait_phase(input st_glue_pkg::bus_phase_e ph);
		int n;
		n = 0;
		do begin
			@(negedge clk_8);
			n++;
		end while (bus_phase != ph && n < 8);
		if (bus_phase != ph) begin
			errors++;
			$display("timeout: bus phase %0d never came", ph);
		end
	endtask

	task automatic wait_ipl(input logic [2:0] exp, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_8);
			n++;
		end while (cpu_ipl !== exp && n < limit);
		if (cpu_ipl !== exp) begin
			errors++;
			$display("timeout: cpu_ipl did not reach %b within %0d cycles", exp, limit);
		end
	endtask

	task automatic wait_berr(input logic exp, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_8);
			n++;
		end while (cpu_berr !== exp && n < limit);
		if (cpu_berr !== exp) begin
			errors++;
			$display("timeout: cpu_berr did not go to %b within %0d cycles", exp, limit);
		end
	endtask

	// drives one full bus cycle and checks the video slot and the cpu slot
	task automatic bus_cycle(input logic [23:0] a, input logic rw, input logic as_n,
		input logic [1:0] ds, input st_glue_pkg::mem_cfg_e cfg, input logic dma);
		logic [31:0] rv;
		logic [5:0] sel_e;
		logic strb, ram_e, mem_e, iack_e, dtack_e;
		logic [7:0] vec_e;
		st_glue_pkg::data_t rdata_e;
		wait_phase(st_glue_pkg::PH_SPARE);
		@(posedge clk_8);
		cpu_addr <= a[23:1];
		cpu_rw <= rw;
		cpu_as_n <= as_n;
		{cpu_uds_n, cpu_lds_n} <= ds;
		mem_cfg <= cfg;
		dma_br <= dma;
		rv = $random(seed);
		ram_rdata <= rv[15:0];
		vreg_rdata <= rv[31:16];
		rv = $random(seed);
		dma_rdata <= rv[15:0];
		mmu_rdata <= rv[23:16];
		mfp_rdata <= rv[31:24];
		rv = $random(seed);
		acia_rdata <= rv[7:0];
		psg_rdata <= rv[15:8];
		video_read <= rv[16];
		rv = $random(seed);
		video_addr <= rv[22:0];
		@(negedge clk_8);
		compare("bus_phase", st_glue_pkg::PH_VIDEO, bus_phase);  // spare wraps to video
		compare("ram_addr", video_addr, ram_addr);  // shifter owns the port
		compare("ram_we_n", 1'b1, ram_we_n);
		compare("ram_oe_n", !video_read, ram_oe_n);
		compare("ram_uds_n", 1'b0, ram_uds_n);  // whole word fetch
		compare("ram_lds_n", 1'b0, ram_lds_n);
		@(negedge clk_8);
		compare("bus_phase", st_glue_pkg::PH_CPU, bus_phase);
		strb = !as_n;  // latched at the end of PH_VIDEO
		ram_e = ram_region(a, cfg);
		mem_e = (a < 24'he00000) || (rw && rom_region(a));
		sel_e = (strb && a[23:16] == `ST_IO_PAGE) ? io_decode(a[15:0]) : 6'd0;
		iack_e = strb && (a[23:4] == `ST_IACK_PAGE);
		vec_e = !iack_e ? 8'h00 : (a[3:1] == 3'd4) ? `ST_VEC_VBI :
			(a[3:1] == 3'd2) ? `ST_VEC_HBI : 8'h00;
		dtack_e = !(strb && (mem_e || sel_e != 6'd0 || iack_e) && !dma);
		rdata_e = mem_e ? ram_rdata : (vreg_rdata | dma_rdata |
			{acia_rdata | psg_rdata, mmu_rdata | mfp_rdata | vec_e});
		compare("selects", sel_e, {vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel});
		compare("io_sel", strb && a[23:16] == `ST_IO_PAGE, io_sel);
		compare("mfp_iack", iack_e && a[3:1] == 3'd6, mfp_iack);
		compare("cpu_dtack_n", dtack_e, cpu_dtack_n);
		compare("cpu_rdata", rdata_e, cpu_rdata);
		compare("ram_addr", a[23:1], ram_addr);
		compare("ram_we_n", !(strb && !rw && ram_e), ram_we_n);
		compare("ram_oe_n", !(strb && rw && mem_e), ram_oe_n);
		compare("ram_uds_n", ds[1], ram_uds_n);
		compare("ram_lds_n", ds[0], ram_lds_n);
	endtask

	// sync pulse, mfp override, then the autovector ack clears it
	task automatic irq_round(input logic hbi);
		logic [2:0] ipl_e;
		ipl_e = hbi ? 3'b101 : 3'b011;
		@(posedge clk_8) {hsync, vsync} <= hbi ? 2'b10 : 2'b01;
		repeat (2) @(posedge clk_8);
		{hsync, vsync} <= 2'b00;
		wait_ipl(ipl_e, 6);
		@(posedge clk_8) mfp_irq <= 1'b1;
		wait_ipl(3'b001, 3);  // mfp beats any pending level
		@(posedge clk_8) mfp_irq <= 1'b0;
		wait_ipl(ipl_e, 3);
		bus_cycle(hbi ? 24'hfffff4 : 24'hfffff8, 1'b1, 1'b0, 2'b00, st_glue_pkg::MEM_4M, 1'b0);
		@(posedge clk_8) cpu_as_n <= 1'b1;
		wait_ipl(3'b111, 6);
	endtask

	initial begin
		logic [31:0] r;
		logic [2:0] cfg_n;
		int i;
		seed = 32'h44a4;
		pll_locked = 1'b0;
		{cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_rw, cpu_clr_berr} = 5'b11111;
		{dma_br, video_read, vsync, hsync, mfp_irq} = 5'b00000;
		cpu_addr = '0;
		video_addr = '0;
		mem_cfg = st_glue_pkg::MEM_4M;
		{ram_rdata, vreg_rdata, dma_rdata} = '0;
		{mmu_rdata, mfp_rdata, acia_rdata, psg_rdata} = '0;
		repeat (2) @(posedge clk_8);
		@(negedge clk_8);
		compare("cpu_ipl", 3'b111, cpu_ipl);  // values held in reset
		compare("cpu_berr", 1'b0, cpu_berr);
		compare("cpu_dtack_n", 1'b1, cpu_dtack_n);
		compare("ram_we_n", 1'b1, ram_we_n);
		compare("selects", 6'd0, {vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel});
		compare("io_sel", 1'b0, io_sel);
		compare("mfp_iack", 1'b0, mfp_iack);
		@(posedge clk_8) pll_locked <= 1'b1;
		for (i = 0; i < 200; i++) begin
			r = $random(seed);
			cfg_n = r[15:8] % 6;
			bus_cycle(pick_addr(), r[0], r[3:1] == 3'd0, (r[6:5] == 2'd0) ? r[8:7] : 2'b00,
				st_glue_pkg::mem_cfg_e'(cfg_n), r[18:16] == 3'd0);  // dma_br 1 in 8
		end
		// bus error on an unmapped io register
		bus_cycle(24'h000000, 1'b1, 1'b1, 2'b11, st_glue_pkg::MEM_4M, 1'b0);
		@(posedge clk_8) cpu_clr_berr <= 1'b0;
		bus_cycle(24'hff1000, 1'b1, 1'b0, 2'b00, st_glue_pkg::MEM_4M, 1'b0);
		wait_berr(1'b1, 40);
		compare("cpu_dtack_n", 1'b1, cpu_dtack_n);
		@(posedge clk_8) cpu_clr_berr <= 1'b1;
		wait_berr(1'b0, 8);
		@(posedge clk_8) {cpu_as_n, cpu_clr_berr} <= 2'b10;
		irq_round(1'b0);  // vbi
		irq_round(1'b1);  // hbi
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: src/address_decoder.sv
// fixed ST map, no IDE/blitter/RTC/STE decode; selects are only valid in PH_CPU with the strobe
`timescale 1ns/10ps
`include "st_glue_macros.svh"

module address_decoder (
	input  st_glue_pkg::word_addr_t cpu_addr,
	input  logic                    cpu_rw,       // 1 = read
	input  st_glue_pkg::mem_cfg_e   mem_cfg,
	input  st_glue_pkg::bus_phase_e phase,
	input  logic                    addr_strobe,  // registered as
	output logic                    vreg_sel,
	output logic                    mmu_sel,
	output logic                    mfp_sel,
	output logic                    acia_sel,
	output logic                    psg_sel,
	output logic                    dma_sel,
	st_sel_if.decoder               sel
);

	logic cyc_ok;          // strobed cpu slot
	logic io_page;
	logic iack_page;
	logic big_ram;         // 8M or 14M config
	logic ram14;           // anything below 14M
	logic rom_hit;         // tos or cartridge

	assign cyc_ok    = (phase == st_glue_pkg::PH_CPU) && addr_strobe;
	assign io_page   = (cpu_addr[23:16] == `ST_IO_PAGE);
	assign iack_page = (cpu_addr[23:4] == `ST_IACK_PAGE);
	assign big_ram   = (mem_cfg == st_glue_pkg::MEM_8M) || (mem_cfg == st_glue_pkg::MEM_14M);

	// first 4M always there, then 8M, then 12M + 2M
	assign ram14 = (cpu_addr[23:22] != 2'b11) || (cpu_addr[23:21] == 3'b110);
	assign sel.ram_hit = (cpu_addr[23:22] == 2'b00) ||
		(big_ram && (cpu_addr[23:22] == 2'b01)) ||
		((mem_cfg == st_glue_pkg::MEM_14M) &&
		((cpu_addr[23:22] == 2'b10) || (cpu_addr[23:21] == 3'b110)));

	assign rom_hit = (cpu_addr[23:18] == `ST_TOS256_BASE) ||
		((cpu_addr[23:16] >= `ST_TOS192_BASE) && (cpu_addr[23:16] < `ST_IO_PAGE)) ||
		(cpu_addr[23:17] == `ST_CART_BASE);

	// rom only answers reads
	assign sel.mem_hit = ram14 || (cpu_rw && rom_hit);

	assign sel.io_sel = cyc_ok && io_page;

	// register windows, low bits masked to the block size
	assign mmu_sel  = sel.io_sel && ({cpu_addr[15:1], 1'd0} == `ST_MMU_BASE);
	assign vreg_sel = sel.io_sel && ({cpu_addr[15:7], 7'd0} == `ST_VREG_BASE);  // 128 byte
	assign dma_sel  = sel.io_sel && ({cpu_addr[15:4], 4'd0} == `ST_DMA_BASE);
	assign psg_sel  = sel.io_sel && ({cpu_addr[15:8], 8'd0} == `ST_PSG_BASE);
	assign mfp_sel  = sel.io_sel && ({cpu_addr[15:6], 6'd0} == `ST_MFP_BASE);   // 64 byte
	assign acia_sel = sel.io_sel && ({cpu_addr[15:8], 8'd0} == `ST_ACIA_BASE);

	// interrupt acknowledge, level sits on a[3:1]
	assign sel.iack       = cyc_ok && iack_page;
	assign sel.iack_level = sel.iack ? cpu_addr[3:1] : 3'd0;
	assign sel.mfp_iack   = sel.iack && (cpu_addr[3:1] == 3'd6);

	assign sel.io_ack = vreg_sel || mmu_sel || mfp_sel || acia_sel ||
		psg_sel || dma_sel || sel.iack;

	// register windows never overlap
	always_comb begin
		a_one_sel: assert #0 ($onehot0({vreg_sel, mmu_sel, mfp_sel, acia_sel, psg_sel, dma_sel}))
			else $error("more than one peripheral select active");
	end

endmodule

// File: src/bus_cycle_ctrl.sv
// 4-slot clk_8 bus cycle; dma_br only suppresses dtack, berr stays up until cpu_clr_berr in PH_CPU
`timescale 1ns/10ps
`include "st_glue_macros.svh"

module bus_cycle_ctrl (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	input  logic                    cpu_as_n,
	input  logic                    cpu_uds_n,
	input  logic                    cpu_lds_n,
	input  logic                    cpu_rw,
	input  logic                    cpu_clr_berr,
	input  logic                    dma_br,       // dma wants the bus
	input  logic                    video_read,
	input  st_glue_pkg::word_addr_t cpu_addr,
	input  st_glue_pkg::word_addr_t video_addr,
	st_sel_if.cycle                 sel,
	output st_glue_pkg::bus_phase_e phase,
	output logic                    addr_strobe,
	output logic                    cpu_dtack_n,
	output logic                    cpu_berr,
	output st_glue_pkg::word_addr_t ram_addr,
	output logic                    ram_oe_n,
	output logic                    ram_we_n,
	output logic                    ram_uds_n,
	output logic                    ram_lds_n
);

	logic       video_slot;
	logic       cpu_slot;
	logic [2:0] berr_cnt;  // cpu slots without dtack

	assign video_slot = (phase == st_glue_pkg::PH_VIDEO);
	assign cpu_slot   = (phase == st_glue_pkg::PH_CPU);

	// free running slot counter, wraps spare -> video
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			phase <= st_glue_pkg::PH_VIDEO;
		else
			phase <= st_glue_pkg::bus_phase_e'(phase + 2'd1);
	end

	// as sampled once per bus cycle, held through all four slots
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			addr_strobe <= 1'b0;
		else if (video_slot)
			addr_strobe <= !cpu_as_n;
	end

	// bus request just stalls the cpu here
	assign cpu_dtack_n = !(addr_strobe && (sel.mem_hit || sel.io_ack) && !dma_br);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			berr_cnt <= 3'd0;
		end else if (cpu_slot) begin
			if (berr_cnt != `ST_BERR_LIMIT) begin
				if (addr_strobe && !cpu_uds_n && !cpu_lds_n && cpu_dtack_n && !dma_br)
					berr_cnt <= berr_cnt + 3'd1;
				else
					berr_cnt <= 3'd0;  // answered or idle
			end else if (cpu_clr_berr) begin
				berr_cnt <= 3'd0;  // cpu took the exception
			end
		end
	end

	assign cpu_berr = (berr_cnt == `ST_BERR_LIMIT);

	// st ram port, video gets its own slot
	assign ram_addr  = video_slot ? video_addr : cpu_addr;
	assign ram_uds_n = video_slot ? 1'b0 : cpu_uds_n;  // video reads whole words
	assign ram_lds_n = video_slot ? 1'b0 : cpu_lds_n;

	always_comb begin
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		if (video_slot) begin
			ram_oe_n = !video_read;
		end else if (cpu_slot) begin
			ram_oe_n = !(addr_strobe && cpu_rw && sel.mem_hit);
			ram_we_n = !(addr_strobe && !cpu_rw && sel.ram_hit);  // no rom writes
		end
	end

	a_we_cpu_slot: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!ram_we_n |-> cpu_slot)
		else $error("ram write outside the cpu slot");

	// berr and dtack must not be seen together by the cpu
	a_berr_dtack: assert property (@(posedge clk_8) disable iff (!pll_locked)
		cpu_berr |-> cpu_dtack_n)
		else $error("bus error while dtack asserted");

endmodule

// File: src/irq_ctrl.sv
// ST interrupt levels only: mfp 6, vbi 4, hbi 2; vsync/hsync are async and sampled on clk_8
`timescale 1ns/10ps
`include "st_glue_macros.svh"

module irq_ctrl (
	input  logic              clk_8,
	input  logic              pll_locked,
	input  logic              vsync,
	input  logic              hsync,
	input  logic              mfp_irq,    // mfp wants level 6
	st_sel_if.irq             sel,
	output st_glue_pkg::ipl_t cpu_ipl,
	output st_glue_pkg::byte_t auto_vector
);

	// index 0 = vbi, 1 = hbi throughout
	logic [1:0] sync_in;
	logic [1:0] sync_s;     // negedge sample
	logic [1:0] sync_d;     // posedge copy
	logic [1:0] sync_rise;  // one clk pulse
	logic [1:0] pend;
	logic [1:0] ack;

	assign sync_in = {hsync, vsync};

	assign ack[0] = sel.iack && (sel.iack_level == 3'd4);
	assign ack[1] = sel.iack && (sel.iack_level == 3'd2);

	always_ff @(negedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			sync_s <= 2'b00;
		else
			sync_s <= sync_in;
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_d    <= 2'b00;
			sync_rise <= 2'b00;
			pend      <= 2'b00;
		end else begin
			sync_d    <= sync_s;
			sync_rise <= sync_s & ~sync_d;
			// ack wins over a new edge in the same cycle
			pend      <= (pend | sync_rise) & ~ack;
		end
	end

	// ipl0 is tied high on the st
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			cpu_ipl <= 3'b111;
		else if (mfp_irq)
			cpu_ipl <= 3'b001;  // level 6
		else if (pend[0])
			cpu_ipl <= 3'b011;  // level 4
		else if (pend[1])
			cpu_ipl <= 3'b101;  // level 2
		else
			cpu_ipl <= 3'b111;
	end

	// cpu core runs vectored only, so supply the autovectors
	assign auto_vector = ack[0] ? `ST_VEC_VBI :
		ack[1] ? `ST_VEC_HBI : 8'h00;

	a_ipl0_high: assert property (@(posedge clk_8) disable iff (!pll_locked)
		cpu_ipl[0])
		else $error("odd ipl level requested");

endmodule

// File: src/read_data_mux.sv
// io buses are wired-or, so every peripheral must drive zero while it is not selected
`timescale 1ns/10ps

module read_data_mux (
	st_sel_if.mux              sel,
	input  st_glue_pkg::data_t ram_rdata,
	input  st_glue_pkg::data_t vreg_rdata,
	input  st_glue_pkg::data_t dma_rdata,
	input  st_glue_pkg::byte_t mmu_rdata,
	input  st_glue_pkg::byte_t mfp_rdata,
	input  st_glue_pkg::byte_t acia_rdata,
	input  st_glue_pkg::byte_t psg_rdata,
	input  st_glue_pkg::byte_t auto_vector,
	output st_glue_pkg::data_t cpu_rdata
);

	st_glue_pkg::byte_t io_hi;  // even byte devices
	st_glue_pkg::byte_t io_lo;  // odd byte devices
	st_glue_pkg::data_t io_word;

	assign io_hi = acia_rdata | psg_rdata;
	assign io_lo = mmu_rdata | mfp_rdata | auto_vector;  // vector rides d7..d0

	// word wide registers use the full bus
	assign io_word = vreg_rdata | dma_rdata | {io_hi, io_lo};

	assign cpu_rdata = sel.mem_hit ? ram_rdata : io_word;

endmodule

// File: src/st_glue_macros.svh
// fixed ST address map and vector numbers; the IO offsets are 16-bit compares against a[15:0]
`ifndef ST_GLUE_MACROS_SVH
`define ST_GLUE_MACROS_SVH

// region prefixes, compared against the top of the byte address
`define ST_IO_PAGE      8'hff     // a[23:16], io page at ff0000
`define ST_IACK_PAGE    20'hfffff // a[23:4], iack cycles at fffff0
`define ST_TOS256_BASE  6'h38     // a[23:18], 256k tos at e00000
`define ST_TOS192_BASE  8'hfc     // a[23:16], 192k tos fc0000 up to the io page
`define ST_CART_BASE    7'h7d     // a[23:17], 128k cartridge at fa0000

// io offsets inside the io page
`define ST_MMU_BASE     16'h8000
`define ST_VREG_BASE    16'h8200
`define ST_DMA_BASE     16'h8600
`define ST_PSG_BASE     16'h8800
`define ST_MFP_BASE     16'hfa00
`define ST_ACIA_BASE    16'hfc00

// auto vectors handed out for the on-chip ipl levels
`define ST_VEC_VBI      8'h1c     // level 4
`define ST_VEC_HBI      8'h1a     // level 2

`define ST_BERR_LIMIT   3'd7      // missing-dtack cpu phases before berr

`endif

// File: src/st_glue_pkg.sv
// shared types of the bus glue; word addresses keep the byte address bit numbering 23..1
package st_glue_pkg;

	typedef logic [23:1] word_addr_t;  // cpu word address, a0 dropped
	typedef logic [15:0] data_t;       // cpu / st ram data word
	typedef logic [7:0]  byte_t;       // 8 bit peripheral data, vector numbers
	typedef logic [2:0]  ipl_t;        // active low ipl

	// four clk_8 slots of one 2 MHz bus cycle
	typedef enum logic [1:0] {
		PH_VIDEO = 2'd0,  // shifter fetch
		PH_CPU   = 2'd1,  // cpu owns ram and io
		PH_IO    = 2'd2,
		PH_SPARE = 2'd3
	} bus_phase_e;

	// st ram size as set by the memory config
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_cfg_e;

endpackage

// File: src/st_glue_top.sv
// bus glue only; cpu, sdram, video and peripherals sit outside and meet it on plain ports
`timescale 1ns/10ps

module st_glue_top (
	input  logic                    clk_8,
	input  logic                    pll_locked,    // only reset
	input  st_glue_pkg::word_addr_t cpu_addr,
	input  logic                    cpu_as_n,
	input  logic                    cpu_uds_n,
	input  logic                    cpu_lds_n,
	input  logic                    cpu_rw,
	input  logic                    cpu_clr_berr,
	input  st_glue_pkg::mem_cfg_e   mem_cfg,
	input  logic                    dma_br,
	input  logic                    video_read,
	input  st_glue_pkg::word_addr_t video_addr,
	input  logic                    vsync,
	input  logic                    hsync,
	input  logic                    mfp_irq,
	input  st_glue_pkg::data_t      ram_rdata,
	input  st_glue_pkg::data_t      vreg_rdata,
	input  st_glue_pkg::data_t      dma_rdata,
	input  st_glue_pkg::byte_t      mmu_rdata,
	input  st_glue_pkg::byte_t      mfp_rdata,
	input  st_glue_pkg::byte_t      acia_rdata,
	input  st_glue_pkg::byte_t      psg_rdata,
	output st_glue_pkg::bus_phase_e bus_phase,     // for the video fetch
	output logic                    cpu_dtack_n,
	output logic                    cpu_berr,
	output st_glue_pkg::ipl_t       cpu_ipl,
	output st_glue_pkg::data_t      cpu_rdata,
	output st_glue_pkg::word_addr_t ram_addr,
	output logic                    ram_oe_n,
	output logic                    ram_we_n,
	output logic                    ram_uds_n,
	output logic                    ram_lds_n,
	output logic                    vreg_sel,
	output logic                    mmu_sel,
	output logic                    mfp_sel,
	output logic                    acia_sel,
	output logic                    psg_sel,
	output logic                    dma_sel,
	output logic                    mfp_iack,      // to the mfp
	output logic                    io_sel         // strobed io page cycle
);

	logic               addr_strobe;
	st_glue_pkg::byte_t auto_vector;

	st_sel_if sel ();

	assign mfp_iack = sel.mfp_iack;
	assign io_sel   = sel.io_sel;

	address_decoder u_dec (
		.cpu_addr(cpu_addr), .cpu_rw(cpu_rw), .mem_cfg(mem_cfg),
		.phase(bus_phase), .addr_strobe(addr_strobe),
		.vreg_sel(vreg_sel), .mmu_sel(mmu_sel), .mfp_sel(mfp_sel),
		.acia_sel(acia_sel), .psg_sel(psg_sel), .dma_sel(dma_sel),
		.sel(sel)
	);

	bus_cycle_ctrl u_cycle (
		.clk_8(clk_8), .pll_locked(pll_locked),
		.cpu_as_n(cpu_as_n), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.cpu_rw(cpu_rw), .cpu_clr_berr(cpu_clr_berr), .dma_br(dma_br),
		.video_read(video_read), .cpu_addr(cpu_addr), .video_addr(video_addr),
		.sel(sel), .phase(bus_phase), .addr_strobe(addr_strobe),
		.cpu_dtack_n(cpu_dtack_n), .cpu_berr(cpu_berr), .ram_addr(ram_addr),
		.ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n),
		.ram_uds_n(ram_uds_n), .ram_lds_n(ram_lds_n)
	);

	irq_ctrl u_irq (
		.clk_8(clk_8), .pll_locked(pll_locked),
		.vsync(vsync), .hsync(hsync), .mfp_irq(mfp_irq),
		.sel(sel), .cpu_ipl(cpu_ipl), .auto_vector(auto_vector)
	);

	read_data_mux u_mux (
		.sel(sel), .ram_rdata(ram_rdata),
		.vreg_rdata(vreg_rdata), .dma_rdata(dma_rdata),
		.mmu_rdata(mmu_rdata), .mfp_rdata(mfp_rdata),
		.acia_rdata(acia_rdata), .psg_rdata(psg_rdata),
		.auto_vector(auto_vector), .cpu_rdata(cpu_rdata)
	);

endmodule

// File: src/st_sel_if.sv
// decoder results; ram_hit and mem_hit are raw decodes, acks and io fields only live in PH_CPU
`timescale 1ns/10ps

interface st_sel_if;

	logic       ram_hit;     // inside configured st ram
	logic       mem_hit;     // ram (14M window) or rom/cart read
	logic       io_ack;      // some peripheral or an iack answers
	logic [2:0] iack_level;  // a[3:1] of the iack, else 0
	logic       iack;        // iack cycle running
	logic       io_sel;      // strobed cpu cycle on the io page
	logic       mfp_iack;    // level 6 ack, belongs to the mfp

	// decoder owns every field
	modport decoder (
		output ram_hit, mem_hit, io_ack, iack_level, iack, io_sel, mfp_iack
	);

	modport cycle (input ram_hit, mem_hit, io_ack);  // dtack and ram strobes
	modport irq   (input iack, iack_level);          // pending clear, vectors
	modport mux   (input mem_hit);                   // ram vs io data

endinterface

// File: vlog.f
+incdir+src
src/st_glue_pkg.sv
src/st_sel_if.sv
src/address_decoder.sv
src/bus_cycle_ctrl.sv
src/irq_ctrl.sv
src/read_data_mux.sv
src/st_glue_top.sv
dv/tb_st_glue.sv
